/* list.f */
+incdir+common
common/mem_pkg.sv
hw/ifu_fetch.sv
hw/lsu_bridge.sv
hw/axi_arbiter.sv
sram/axi_sram.sv
hw/mem_subsys_top.sv
verif/tb_mem_subsys.sv

/* Makefile */
# Verilator build for the memory subsystem testbench.
# Override any variable on the command line, e.g. make BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys_top
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILE_LIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

# A $fatal in the testbench gives a non-zero exit status.
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verif/tb_mem_subsys.sv */
`include "mem_defines.svh"

module tb_mem_subsys import mem_pkg::*; ();

  localparam int   TIMEOUT_CYCLES = 100;
  localparam int   BYTE_IDX_W     = $clog2(4 * `MEM_DEPTH_WORDS);
  localparam logic PORT_FETCH     = 1'b0;
  localparam logic PORT_LSU       = 1'b1;

  typedef struct {
    logic                   port;
    logic                   store;
    logic [`MEM_ADDR_W-1:0] addr;
    size_t                  acc_size;
    logic                   uns;
    logic [`MEM_DATA_W-1:0] wdata;
    logic [`MEM_DATA_W-1:0] exp_data;
    logic                   exp_err;
    logic                   pair;     // Issued in the same cycle as the next row.
  } row_t;

  logic                   clk;
  logic                   rst;
  logic                   fetch_req_i;
  logic [`MEM_ADDR_W-1:0] fetch_pc_i;
  logic                   fetch_ready_o;
  logic                   inst_valid_o;
  logic [`MEM_DATA_W-1:0] inst_o;
  logic                   inst_err_o;
  logic                   lsu_req_i;
  logic                   lsu_we_i;
  logic [`MEM_ADDR_W-1:0] lsu_addr_i;
  size_t                  lsu_size_i;
  logic                   lsu_unsigned_i;
  logic [`MEM_DATA_W-1:0] lsu_wdata_i;
  logic                   lsu_ready_o;
  logic                   lsu_resp_valid_o;
  logic [`MEM_DATA_W-1:0] lsu_rdata_o;
  logic                   lsu_err_o;

  row_t       rows[$];
  logic [7:0] ref_mem [4 * `MEM_DEPTH_WORDS]; // Byte view of the SRAM.

  mem_subsys_top i_mem_subsys_top (
    .clk, .rst,
    .fetch_req_i, .fetch_pc_i, .fetch_ready_o, .inst_valid_o, .inst_o, .inst_err_o,
    .lsu_req_i, .lsu_we_i, .lsu_addr_i, .lsu_size_i, .lsu_unsigned_i, .lsu_wdata_i,
    .lsu_ready_o, .lsu_resp_valid_o, .lsu_rdata_o, .lsu_err_o
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic timeout_failure(input string what);
    $display("Timeout at %0t: %s for %0d cycles", $time, what, TIMEOUT_CYCLES);
    stop_on_failure();
  endtask

  task automatic check_data(input logic [`MEM_DATA_W-1:0] got,
                            input logic [`MEM_DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %08h expected %08h", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_resp(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0b expected %0b", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  // Misaligned or out of range accesses fail.
  function automatic logic model_error(input logic port, input logic [`MEM_ADDR_W-1:0] addr,
                                       input size_t acc_size);
    logic misaligned;
    if (port == PORT_FETCH || acc_size == SIZE_WORD) begin
      misaligned = (addr[1:0] != 2'b00);
    end else if (acc_size == SIZE_HALF) begin
      misaligned = addr[0];
    end else begin
      misaligned = 1'b0;
    end
    return misaligned || (addr >= 4 * `MEM_DEPTH_WORDS);
  endfunction

  function automatic logic [`MEM_DATA_W-1:0] model_load(input logic [`MEM_ADDR_W-1:0] addr,
                                                        input size_t acc_size, input logic uns);
    logic [BYTE_IDX_W-1:0] idx;
    logic [7:0]            b0;
    logic [7:0]            b1;
    idx = addr[BYTE_IDX_W-1:0];
    b0  = ref_mem[idx];
    b1  = ref_mem[idx + 2'd1];
    case (acc_size)
      SIZE_BYTE: return uns ? {24'h0, b0} : {{24{b0[7]}}, b0};
      SIZE_HALF: return uns ? {16'h0, b1, b0} : {{16{b1[7]}}, b1, b0};
      default:   return {ref_mem[idx + 2'd3], ref_mem[idx + 2'd2], b1, b0}; // Little endian.
    endcase
  endfunction

  task automatic model_store(input logic [`MEM_ADDR_W-1:0] addr, input size_t acc_size,
                             input logic [`MEM_DATA_W-1:0] wdata);
    logic [BYTE_IDX_W-1:0] idx;
    idx = addr[BYTE_IDX_W-1:0];
    ref_mem[idx] = wdata[7:0];
    if (acc_size != SIZE_BYTE) ref_mem[idx + 2'd1] = wdata[15:8];
    if (acc_size == SIZE_WORD) begin
      ref_mem[idx + 2'd2] = wdata[23:16];
      ref_mem[idx + 2'd3] = wdata[31:24];
    end
  endtask

  task automatic fetch_access(input logic [`MEM_ADDR_W-1:0] addr,
                              output logic [`MEM_DATA_W-1:0] data, output logic err);
    int cycles;
    @(posedge clk);
    fetch_req_i <= 1'b1;
    fetch_pc_i  <= addr;
    cycles = 0;
    @(negedge clk);
    while (!fetch_ready_o) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) timeout_failure("fetch_ready_o stayed low");
      @(negedge clk);
    end
    @(posedge clk); // Accepted at this edge.
    fetch_req_i <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!inst_valid_o) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) timeout_failure("no inst_valid_o pulse");
      @(negedge clk);
    end
    data = inst_o;
    err  = inst_err_o;
  endtask

  task automatic lsu_access(input row_t r, output logic [`MEM_DATA_W-1:0] data,
                            output logic err);
    int cycles;
    @(posedge clk);
    lsu_req_i      <= 1'b1;
    lsu_we_i       <= r.store;
    lsu_addr_i     <= r.addr;
    lsu_size_i     <= r.acc_size;
    lsu_unsigned_i <= r.uns;
    lsu_wdata_i    <= r.wdata;
    cycles = 0;
    @(negedge clk);
    while (!lsu_ready_o) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) timeout_failure("lsu_ready_o stayed low");
      @(negedge clk);
    end
    @(posedge clk);
    lsu_req_i <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!lsu_resp_valid_o) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) timeout_failure("no lsu_resp_valid_o pulse");
      @(negedge clk);
    end
    data = lsu_rdata_o;
    err  = lsu_err_o;
  endtask

  task automatic run_row(input int n, input row_t r);
    logic                   exp_err;
    logic [`MEM_DATA_W-1:0] exp_data;
    logic [`MEM_DATA_W-1:0] got_data;
    logic                   got_err;
    exp_err  = model_error(r.port, r.addr, r.acc_size);
    exp_data = '0;
    if (!r.store && !exp_err) begin
      exp_data = (r.port == PORT_FETCH) ? model_load(r.addr, SIZE_WORD, 1'b1)
                                        : model_load(r.addr, r.acc_size, r.uns);
      check_data(exp_data, r.exp_data, $sformatf("row %0d table data vs model", n));
    end
    check_resp(exp_err, r.exp_err, $sformatf("row %0d table error vs model", n));
    if (r.port == PORT_FETCH) fetch_access(r.addr, got_data, got_err);
    else lsu_access(r, got_data, got_err);
    check_resp(got_err, exp_err, $sformatf("row %0d error flag", n));
    if (!r.store && !exp_err) check_data(got_data, exp_data, $sformatf("row %0d data", n));
    if (r.store && !exp_err) model_store(r.addr, r.acc_size, r.wdata);
  endtask

  task automatic add_row(input logic port, input logic store, input logic [31:0] addr,
                         input size_t acc_size, input logic uns, input logic [31:0] wdata,
                         input logic [31:0] exp_data, input logic exp_err, input logic pair);
    rows.push_back('{port, store, addr, acc_size, uns, wdata, exp_data, exp_err, pair});
  endtask

  task automatic build_table();
    // Port, store, address, size, unsigned, write data, expected data, error, paired.
    add_row(PORT_LSU, 1'b1, 32'h0000_0100, SIZE_WORD, 1'b0, 32'hdead_beef, 32'h0, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0100, SIZE_WORD, 1'b0, 32'h0, 32'hdead_beef, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b1, 32'h0000_0000, SIZE_WORD, 1'b0, 32'h1122_3344, 32'h0, 1'b0, 1'b0);
    // Lane merges and extension.
    add_row(PORT_LSU, 1'b1, 32'h0000_0101, SIZE_BYTE, 1'b0, 32'h0000_00a5, 32'h0, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b1, 32'h0000_0102, SIZE_HALF, 1'b0, 32'h0000_1234, 32'h0, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0100, SIZE_WORD, 1'b0, 32'h0, 32'h1234_a5ef, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0101, SIZE_BYTE, 1'b0, 32'h0, 32'hffff_ffa5, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0101, SIZE_BYTE, 1'b1, 32'h0, 32'h0000_00a5, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0100, SIZE_HALF, 1'b0, 32'h0, 32'hffff_a5ef, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0100, SIZE_HALF, 1'b1, 32'h0, 32'h0000_a5ef, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0102, SIZE_HALF, 1'b0, 32'h0, 32'h0000_1234, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0103, SIZE_BYTE, 1'b0, 32'h0, 32'h0000_0012, 1'b0, 1'b0);
    // Code written by stores, then fetched.
    add_row(PORT_LSU, 1'b1, 32'h0000_0200, SIZE_WORD, 1'b0, 32'h0000_0013, 32'h0, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b1, 32'h0000_0204, SIZE_WORD, 1'b0, 32'h00a0_0093, 32'h0, 1'b0, 1'b0);
    add_row(PORT_FETCH, 1'b0, 32'h0000_0200, SIZE_WORD, 1'b0, 32'h0, 32'h0000_0013, 1'b0, 1'b0);
    add_row(PORT_FETCH, 1'b0, 32'h0000_0204, SIZE_WORD, 1'b0, 32'h0, 32'h00a0_0093, 1'b0, 1'b0);
    // Out of range, 0x1000 would alias word 0.
    add_row(PORT_LSU, 1'b0, 32'h0000_1000, SIZE_WORD, 1'b0, 32'h0, 32'h0, 1'b1, 1'b0);
    add_row(PORT_LSU, 1'b1, 32'h0000_1000, SIZE_WORD, 1'b0, 32'hffff_ffff, 32'h0, 1'b1, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0000, SIZE_WORD, 1'b0, 32'h0, 32'h1122_3344, 1'b0, 1'b0);
    add_row(PORT_FETCH, 1'b0, 32'h0000_2000, SIZE_WORD, 1'b0, 32'h0, 32'h0, 1'b1, 1'b0);
    add_row(PORT_LSU, 1'b1, 32'h0000_1001, SIZE_BYTE, 1'b0, 32'h0000_00ff, 32'h0, 1'b1, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0001, SIZE_BYTE, 1'b1, 32'h0, 32'h0000_0033, 1'b0, 1'b0);
    // Misaligned accesses.
    add_row(PORT_LSU, 1'b0, 32'h0000_0101, SIZE_HALF, 1'b0, 32'h0, 32'h0, 1'b1, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0102, SIZE_WORD, 1'b0, 32'h0, 32'h0, 1'b1, 1'b0);
    add_row(PORT_FETCH, 1'b0, 32'h0000_0202, SIZE_WORD, 1'b0, 32'h0, 32'h0, 1'b1, 1'b0);
    add_row(PORT_LSU, 1'b1, 32'h0000_0102, SIZE_WORD, 1'b0, 32'hffff_ffff, 32'h0, 1'b1, 1'b0);
    add_row(PORT_LSU, 1'b1, 32'h0000_0103, SIZE_HALF, 1'b0, 32'h0000_ffff, 32'h0, 1'b1, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0100, SIZE_WORD, 1'b0, 32'h0, 32'h1234_a5ef, 1'b0, 1'b0);
    // Fetch and load/store in the same cycle.
    add_row(PORT_FETCH, 1'b0, 32'h0000_0204, SIZE_WORD, 1'b0, 32'h0, 32'h00a0_0093, 1'b0, 1'b1);
    add_row(PORT_LSU, 1'b0, 32'h0000_0100, SIZE_WORD, 1'b0, 32'h0, 32'h1234_a5ef, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b1, 32'h0000_0300, SIZE_WORD, 1'b0, 32'hcafe_f00d, 32'h0, 1'b0, 1'b1);
    add_row(PORT_FETCH, 1'b0, 32'h0000_0200, SIZE_WORD, 1'b0, 32'h0, 32'h0000_0013, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0300, SIZE_BYTE, 1'b1, 32'h0, 32'h0000_000d, 1'b0, 1'b1);
    add_row(PORT_FETCH, 1'b0, 32'h0000_0300, SIZE_WORD, 1'b0, 32'h0, 32'hcafe_f00d, 1'b0, 1'b0);
    add_row(PORT_LSU, 1'b0, 32'h0000_0302, SIZE_HALF, 1'b0, 32'h0, 32'hffff_cafe, 1'b0, 1'b0);
  endtask

  initial begin
    int i;
    rst            <= 1'b0;
    fetch_req_i    <= 1'b0;
    fetch_pc_i     <= '0;
    lsu_req_i      <= 1'b0;
    lsu_we_i       <= 1'b0;
    lsu_addr_i     <= '0;
    lsu_size_i     <= SIZE_WORD;
    lsu_unsigned_i <= 1'b0;
    lsu_wdata_i    <= '0;
    build_table();
    repeat (5) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_resp(inst_valid_o, 1'b0, "inst_valid_o after reset");
    check_resp(lsu_resp_valid_o, 1'b0, "lsu_resp_valid_o after reset");
    check_resp(fetch_ready_o, 1'b1, "fetch_ready_o after reset");
    check_resp(lsu_ready_o, 1'b1, "lsu_ready_o after reset");
    i = 0;
    while (i < rows.size()) begin
      if (rows[i].pair && (i + 1 < rows.size())) begin
        fork
          run_row(i, rows[i]);
          run_row(i + 1, rows[i + 1]);
        join
        i += 2;
      end else begin
        run_row(i, rows[i]);
        i++;
      end
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* hw/mem_subsys_top.sv */
`include "mem_defines.svh"

module mem_subsys_top import mem_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fetch_req_i,
  input  logic [`MEM_ADDR_W-1:0] fetch_pc_i,
  output logic                   fetch_ready_o,
  output logic                   inst_valid_o,
  output logic [`MEM_DATA_W-1:0] inst_o,
  output logic                   inst_err_o,
  input  logic                   lsu_req_i,
  input  logic                   lsu_we_i,
  input  logic [`MEM_ADDR_W-1:0] lsu_addr_i,
  input  size_t                  lsu_size_i,
  input  logic                   lsu_unsigned_i,
  input  logic [`MEM_DATA_W-1:0] lsu_wdata_i,
  output logic                   lsu_ready_o,
  output logic                   lsu_resp_valid_o,
  output logic [`MEM_DATA_W-1:0] lsu_rdata_o,
  output logic                   lsu_err_o
);

  logic [`MEM_ADDR_W-1:0]   m0_araddr, m1_araddr, m1_awaddr, s_araddr, s_awaddr;
  logic [`MEM_DATA_W-1:0]   m0_rdata, m1_rdata, m1_wdata, s_rdata, s_wdata;
  logic [`MEM_DATA_W/8-1:0] m1_wstrb, s_wstrb;
  resp_t                    m0_rresp, m1_rresp, m1_bresp, s_rresp, s_bresp;
  logic                     m0_arvalid, m0_arready, m0_rvalid, m0_rready;
  logic                     m1_arvalid, m1_arready, m1_rvalid, m1_rready;
  logic                     m1_awvalid, m1_awready, m1_wvalid, m1_wready;
  logic                     m1_bvalid, m1_bready;
  logic                     s_arvalid, s_arready, s_rvalid, s_rready;
  logic                     s_awvalid, s_awready, s_wvalid, s_wready;
  logic                     s_bvalid, s_bready;

  ifu_fetch i_ifu_fetch (
    .clk, .rst,
    .fetch_req_i, .fetch_pc_i, .fetch_ready_o, .inst_valid_o, .inst_o, .inst_err_o,
    .m_araddr_o(m0_araddr), .m_arvalid_o(m0_arvalid), .m_arready_i(m0_arready),
    .m_rdata_i(m0_rdata), .m_rresp_i(m0_rresp), .m_rvalid_i(m0_rvalid),
    .m_rready_o(m0_rready)
  );

  lsu_bridge i_lsu_bridge (
    .clk, .rst,
    .req_i(lsu_req_i), .we_i(lsu_we_i), .addr_i(lsu_addr_i), .size_i(lsu_size_i),
    .unsigned_i(lsu_unsigned_i), .wdata_i(lsu_wdata_i), .ready_o(lsu_ready_o),
    .resp_valid_o(lsu_resp_valid_o), .rdata_o(lsu_rdata_o), .err_o(lsu_err_o),
    .m_araddr_o(m1_araddr), .m_arvalid_o(m1_arvalid), .m_arready_i(m1_arready),
    .m_rdata_i(m1_rdata), .m_rresp_i(m1_rresp), .m_rvalid_i(m1_rvalid),
    .m_rready_o(m1_rready),
    .m_awaddr_o(m1_awaddr), .m_awvalid_o(m1_awvalid), .m_awready_i(m1_awready),
    .m_wdata_o(m1_wdata), .m_wstrb_o(m1_wstrb), .m_wvalid_o(m1_wvalid),
    .m_wready_i(m1_wready),
    .m_bresp_i(m1_bresp), .m_bvalid_i(m1_bvalid), .m_bready_o(m1_bready)
  );

  axi_arbiter i_axi_arbiter (
    .clk, .rst,
    .m0_araddr_i(m0_araddr), .m0_arvalid_i(m0_arvalid), .m0_arready_o(m0_arready),
    .m0_rdata_o(m0_rdata), .m0_rresp_o(m0_rresp), .m0_rvalid_o(m0_rvalid),
    .m0_rready_i(m0_rready),
    .m1_araddr_i(m1_araddr), .m1_arvalid_i(m1_arvalid), .m1_arready_o(m1_arready),
    .m1_rdata_o(m1_rdata), .m1_rresp_o(m1_rresp), .m1_rvalid_o(m1_rvalid),
    .m1_rready_i(m1_rready),
    .m1_awaddr_i(m1_awaddr), .m1_awvalid_i(m1_awvalid), .m1_awready_o(m1_awready),
    .m1_wdata_i(m1_wdata), .m1_wstrb_i(m1_wstrb), .m1_wvalid_i(m1_wvalid),
    .m1_wready_o(m1_wready),
    .m1_bresp_o(m1_bresp), .m1_bvalid_o(m1_bvalid), .m1_bready_i(m1_bready),
    .s_araddr_o(s_araddr), .s_arvalid_o(s_arvalid), .s_arready_i(s_arready),
    .s_rdata_i(s_rdata), .s_rresp_i(s_rresp), .s_rvalid_i(s_rvalid),
    .s_rready_o(s_rready),
    .s_awaddr_o(s_awaddr), .s_awvalid_o(s_awvalid), .s_awready_i(s_awready),
    .s_wdata_o(s_wdata), .s_wstrb_o(s_wstrb), .s_wvalid_o(s_wvalid),
    .s_wready_i(s_wready),
    .s_bresp_i(s_bresp), .s_bvalid_i(s_bvalid), .s_bready_o(s_bready)
  );

  axi_sram i_axi_sram (
    .clk, .rst,
    .araddr_i(s_araddr), .arvalid_i(s_arvalid), .arready_o(s_arready),
    .rdata_o(s_rdata), .rresp_o(s_rresp), .rvalid_o(s_rvalid), .rready_i(s_rready),
    .awaddr_i(s_awaddr), .awvalid_i(s_awvalid), .awready_o(s_awready),
    .wdata_i(s_wdata), .wstrb_i(s_wstrb), .wvalid_i(s_wvalid), .wready_o(s_wready),
    .bresp_o(s_bresp), .bvalid_o(s_bvalid), .bready_i(s_bready)
  );

endmodule

/* sram/axi_sram.sv */
`include "mem_defines.svh"

module axi_sram import mem_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`MEM_ADDR_W-1:0]   araddr_i,
  input  logic                     arvalid_i,
  output logic                     arready_o,
  output logic [`MEM_DATA_W-1:0]   rdata_o,
  output resp_t                    rresp_o,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  input  logic [`MEM_ADDR_W-1:0]   awaddr_i,
  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  logic [`MEM_DATA_W-1:0]   wdata_i,
  input  logic [`MEM_DATA_W/8-1:0] wstrb_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  output resp_t                    bresp_o,
  output logic                     bvalid_o,
  input  logic                     bready_i
);

  localparam int IDX_W = $clog2(`MEM_DEPTH_WORDS);

  typedef enum logic [2:0] {
    ST_IDLE, ST_READ, ST_WAIT_RREADY, ST_WAIT_WVALID, ST_WRITE, ST_WAIT_BREADY
  } state_t;

  state_t                 state_q;
  state_t                 state_d;
  logic [3:0]             rd_cnt_q;
  logic [3:0]             wr_cnt_q;
  logic [`MEM_ADDR_W-1:0] awaddr_q;
  logic                   rd_ok;
  logic                   wr_ok;
  logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH_WORDS];

  assign arready_o = (state_q == ST_IDLE);
  assign awready_o = (state_q == ST_IDLE) && !arvalid_i; // Reads win.
  assign rvalid_o  = (state_q == ST_WAIT_RREADY);
  assign wready_o  = (state_q == ST_WAIT_WVALID);
  assign bvalid_o  = (state_q == ST_WAIT_BREADY);

  // Range checks on the word address.
  assign rd_ok = (araddr_i[`MEM_ADDR_W-1:2] < `MEM_DEPTH_WORDS);
  assign wr_ok = (awaddr_q[`MEM_ADDR_W-1:2] < `MEM_DEPTH_WORDS);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (arvalid_i) begin
          state_d = ST_READ;
        end else if (awvalid_i) begin
          state_d = ST_WAIT_WVALID;
        end
      end
      ST_READ:        if (rd_cnt_q == `MEM_RD_LAT - 1) state_d = ST_WAIT_RREADY;
      ST_WAIT_RREADY: if (rready_i) state_d = ST_IDLE;
      ST_WAIT_WVALID: if (wvalid_i) state_d = ST_WRITE;
      ST_WRITE:       if (wr_cnt_q == `MEM_WR_LAT - 1) state_d = ST_WAIT_BREADY;
      ST_WAIT_BREADY: if (bready_i) state_d = ST_IDLE;
      default:        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q  <= ST_IDLE;
      rd_cnt_q <= '0;
      wr_cnt_q <= '0;
    end else begin
      state_q  <= state_d;
      rd_cnt_q <= (state_q == ST_READ) ? rd_cnt_q + 4'd1 : 4'd0;
      wr_cnt_q <= (state_q == ST_WRITE) ? wr_cnt_q + 4'd1 : 4'd0;
    end
  end

  // Storage and response payload.
  always_ff @(posedge clk) begin
    if (arvalid_i && arready_o) begin
      rdata_o <= rd_ok ? mem[araddr_i[IDX_W+1:2]] : '0;
      rresp_o <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (awvalid_i && awready_o) awaddr_q <= awaddr_i;
    if (wvalid_i && wready_o) begin
      bresp_o <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      for (int b = 0; b < `MEM_DATA_W / 8; b++) begin
        if (wr_ok && wstrb_i[b]) begin
          mem[awaddr_q[IDX_W+1:2]][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

/* hw/axi_arbiter.sv */
`include "mem_defines.svh"

module axi_arbiter import mem_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  // Fetch master, read channels.
  input  logic [`MEM_ADDR_W-1:0]   m0_araddr_i,
  input  logic                     m0_arvalid_i,
  output logic                     m0_arready_o,
  output logic [`MEM_DATA_W-1:0]   m0_rdata_o,
  output resp_t                    m0_rresp_o,
  output logic                     m0_rvalid_o,
  input  logic                     m0_rready_i,
  // Load/store master.
  input  logic [`MEM_ADDR_W-1:0]   m1_araddr_i,
  input  logic                     m1_arvalid_i,
  output logic                     m1_arready_o,
  output logic [`MEM_DATA_W-1:0]   m1_rdata_o,
  output resp_t                    m1_rresp_o,
  output logic                     m1_rvalid_o,
  input  logic                     m1_rready_i,
  input  logic [`MEM_ADDR_W-1:0]   m1_awaddr_i,
  input  logic                     m1_awvalid_i,
  output logic                     m1_awready_o,
  input  logic [`MEM_DATA_W-1:0]   m1_wdata_i,
  input  logic [`MEM_DATA_W/8-1:0] m1_wstrb_i,
  input  logic                     m1_wvalid_i,
  output logic                     m1_wready_o,
  output resp_t                    m1_bresp_o,
  output logic                     m1_bvalid_o,
  input  logic                     m1_bready_i,
  // Shared SRAM side.
  output logic [`MEM_ADDR_W-1:0]   s_araddr_o,
  output logic                     s_arvalid_o,
  input  logic                     s_arready_i,
  input  logic [`MEM_DATA_W-1:0]   s_rdata_i,
  input  resp_t                    s_rresp_i,
  input  logic                     s_rvalid_i,
  output logic                     s_rready_o,
  output logic [`MEM_ADDR_W-1:0]   s_awaddr_o,
  output logic                     s_awvalid_o,
  input  logic                     s_awready_i,
  output logic [`MEM_DATA_W-1:0]   s_wdata_o,
  output logic [`MEM_DATA_W/8-1:0] s_wstrb_o,
  output logic                     s_wvalid_o,
  input  logic                     s_wready_i,
  input  resp_t                    s_bresp_i,
  input  logic                     s_bvalid_i,
  output logic                     s_bready_o
);

  logic grant_q; // 0 is fetch, 1 is load/store.
  logic busy_q;
  logic last_q;
  logic m0_req;
  logic m1_req;
  logic pick;
  logic sel;
  logic done;

  assign m0_req = m0_arvalid_i;
  assign m1_req = m1_arvalid_i | m1_awvalid_i;
  assign pick   = (m0_req && m1_req) ? ~last_q : m1_req; // Loser of last round wins.
  assign sel    = busy_q ? grant_q : pick;
  assign done   = (s_rvalid_i && s_rready_o) || (s_bvalid_i && s_bready_o);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      grant_q <= 1'b0;
      busy_q  <= 1'b0;
      last_q  <= 1'b0;
    end else if (!busy_q && (m0_req || m1_req)) begin
      grant_q <= pick;
      busy_q  <= 1'b1;
    end else if (busy_q && done) begin // Released on the response handshake.
      busy_q <= 1'b0;
      last_q <= grant_q;
    end
  end

  // Read channels.
  assign s_araddr_o   = sel ? m1_araddr_i : m0_araddr_i;
  assign s_arvalid_o  = sel ? m1_arvalid_i : m0_arvalid_i;
  assign m0_arready_o = !sel && s_arready_i;
  assign m1_arready_o = sel && s_arready_i;
  assign s_rready_o   = sel ? m1_rready_i : m0_rready_i;
  assign m0_rvalid_o  = !sel && s_rvalid_i;
  assign m1_rvalid_o  = sel && s_rvalid_i;
  assign m0_rdata_o   = s_rdata_i;
  assign m1_rdata_o   = s_rdata_i;
  assign m0_rresp_o   = s_rresp_i;
  assign m1_rresp_o   = s_rresp_i;

  // Write channels, load/store only.
  assign s_awaddr_o   = m1_awaddr_i;
  assign s_awvalid_o  = sel && m1_awvalid_i;
  assign m1_awready_o = sel && s_awready_i;
  assign s_wdata_o    = m1_wdata_i;
  assign s_wstrb_o    = m1_wstrb_i;
  assign s_wvalid_o   = sel && m1_wvalid_i;
  assign m1_wready_o  = sel && s_wready_i;
  assign m1_bresp_o   = s_bresp_i;
  assign m1_bvalid_o  = sel && s_bvalid_i;
  assign s_bready_o   = sel && m1_bready_i;

endmodule

/* hw/lsu_bridge.sv */
`include "mem_defines.svh"

module lsu_bridge import mem_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [`MEM_ADDR_W-1:0]   addr_i,
  input  size_t                    size_i,
  input  logic                     unsigned_i,
  input  logic [`MEM_DATA_W-1:0]   wdata_i,
  output logic                     ready_o,
  output logic                     resp_valid_o,
  output logic [`MEM_DATA_W-1:0]   rdata_o,
  output logic                     err_o,
  output logic [`MEM_ADDR_W-1:0]   m_araddr_o,
  output logic                     m_arvalid_o,
  input  logic                     m_arready_i,
  input  logic [`MEM_DATA_W-1:0]   m_rdata_i,
  input  resp_t                    m_rresp_i,
  input  logic                     m_rvalid_i,
  output logic                     m_rready_o,
  output logic [`MEM_ADDR_W-1:0]   m_awaddr_o,
  output logic                     m_awvalid_o,
  input  logic                     m_awready_i,
  output logic [`MEM_DATA_W-1:0]   m_wdata_o,
  output logic [`MEM_DATA_W/8-1:0] m_wstrb_o,
  output logic                     m_wvalid_o,
  input  logic                     m_wready_i,
  input  resp_t                    m_bresp_i,
  input  logic                     m_bvalid_i,
  output logic                     m_bready_o
);

  typedef enum logic [2:0] {ST_IDLE, ST_AR, ST_R, ST_AW, ST_W, ST_B} state_t;

  state_t                   state_q;
  logic [`MEM_ADDR_W-1:0]   addr_q;
  size_t                    size_q;
  logic                     unsigned_q;
  logic [`MEM_DATA_W-1:0]   wdata_q;
  logic [`MEM_DATA_W/8-1:0] wstrb_q;
  logic                     misaligned;
  logic [`MEM_DATA_W/8-1:0] strb;
  logic [`MEM_DATA_W-1:0]   shifted;
  logic [`MEM_DATA_W-1:0]   load_val;

  assign ready_o     = (state_q == ST_IDLE);
  assign m_arvalid_o = (state_q == ST_AR);
  assign m_rready_o  = (state_q == ST_R);
  assign m_awvalid_o = (state_q == ST_AW);
  assign m_wvalid_o  = (state_q == ST_W);
  assign m_bready_o  = (state_q == ST_B);
  assign m_araddr_o  = {addr_q[`MEM_ADDR_W-1:2], 2'b00}; // Word address.
  assign m_awaddr_o  = {addr_q[`MEM_ADDR_W-1:2], 2'b00};
  assign m_wdata_o   = wdata_q;
  assign m_wstrb_o   = wstrb_q;

  assign misaligned = ((size_i == SIZE_HALF) && addr_i[0]) ||
                      ((size_i == SIZE_WORD) && (addr_i[1:0] != 2'b00));

  // Strobe for the request, and the loaded lane moved down to bit 0.
  assign shifted = m_rdata_i >> {addr_q[1:0], 3'b000};

  always_comb begin
    case (size_i)
      SIZE_BYTE: strb = 4'b0001 << addr_i[1:0];
      SIZE_HALF: strb = 4'b0011 << addr_i[1:0];
      default:   strb = 4'b1111;
    endcase
    case (size_q)
      SIZE_BYTE: load_val = {{24{~unsigned_q & shifted[7]}}, shifted[7:0]};
      SIZE_HALF: load_val = {{16{~unsigned_q & shifted[15]}}, shifted[15:0]};
      default:   load_val = m_rdata_i;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q      <= ST_IDLE;
      resp_valid_o <= 1'b0;
      err_o        <= 1'b0;
    end else begin
      resp_valid_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            if (misaligned) begin // Trapped locally.
              resp_valid_o <= 1'b1;
              err_o        <= 1'b1;
            end else begin
              state_q <= we_i ? ST_AW : ST_AR;
            end
          end
        end
        ST_AR: if (m_arready_i) state_q <= ST_R;
        ST_R: begin
          if (m_rvalid_i) begin
            resp_valid_o <= 1'b1;
            err_o        <= (m_rresp_i == RESP_SLVERR);
            state_q      <= ST_IDLE;
          end
        end
        ST_AW: if (m_awready_i) state_q <= ST_W; // Address first, then data.
        ST_W:  if (m_wready_i) state_q <= ST_B;
        ST_B: begin
          if (m_bvalid_i) begin
            resp_valid_o <= 1'b1;
            err_o        <= (m_bresp_i == RESP_SLVERR);
            state_q      <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_i && ready_o) begin
      addr_q     <= addr_i;
      size_q     <= size_i;
      unsigned_q <= unsigned_i;
      wdata_q    <= wdata_i << {addr_i[1:0], 3'b000}; // Into its byte lanes.
      wstrb_q    <= strb;
    end
    if (m_rvalid_i && m_rready_o) rdata_o <= load_val;
  end

endmodule

/* hw/ifu_fetch.sv */
`include "mem_defines.svh"

module ifu_fetch import mem_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fetch_req_i,
  input  logic [`MEM_ADDR_W-1:0] fetch_pc_i,
  output logic                   fetch_ready_o,
  output logic                   inst_valid_o,
  output logic [`MEM_DATA_W-1:0] inst_o,
  output logic                   inst_err_o,
  output logic [`MEM_ADDR_W-1:0] m_araddr_o,
  output logic                   m_arvalid_o,
  input  logic                   m_arready_i,
  input  logic [`MEM_DATA_W-1:0] m_rdata_i,
  input  resp_t                  m_rresp_i,
  input  logic                   m_rvalid_i,
  output logic                   m_rready_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA} state_t;

  state_t                 state_q;
  logic [`MEM_ADDR_W-1:0] pc_q;

  assign fetch_ready_o = (state_q == ST_IDLE);
  assign m_arvalid_o   = (state_q == ST_ADDR);
  assign m_araddr_o    = pc_q;
  assign m_rready_o    = (state_q == ST_DATA);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q      <= ST_IDLE;
      inst_valid_o <= 1'b0;
      inst_err_o   <= 1'b0;
    end else begin
      inst_valid_o <= 1'b0; // Response is a single pulse.
      case (state_q)
        ST_IDLE: begin
          if (fetch_req_i) begin
            if (fetch_pc_i[1:0] != 2'b00) begin // Misaligned, no bus access.
              inst_valid_o <= 1'b1;
              inst_err_o   <= 1'b1;
            end else begin
              state_q <= ST_ADDR;
            end
          end
        end
        ST_ADDR: if (m_arready_i) state_q <= ST_DATA;
        ST_DATA: begin
          if (m_rvalid_i) begin
            inst_valid_o <= 1'b1;
            inst_err_o   <= (m_rresp_i == RESP_SLVERR);
            state_q      <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_req_i && fetch_ready_o) pc_q <= fetch_pc_i;
    if (m_rvalid_i && m_rready_o) inst_o <= m_rdata_i;
  end

endmodule

/* common/mem_pkg.sv */
package mem_pkg;

  // Channel response, encoded as on AXI.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_t;

  // Load/store access size.
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } size_t;

endpackage

/* common/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Bus widths.
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// SRAM size in 32-bit words.
`define MEM_DEPTH_WORDS 1024

// Cycles spent in the SRAM read and write states.
`define MEM_RD_LAT 3
`define MEM_WR_LAT 2

`endif
